// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fetch_top
SEED      ?= 965659ea
FILELIST  ?= fetch_top.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=\'h$(SEED) \
		-f $(FILELIST) --Mdir $(BUILD)

run: compile
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf $(BUILD)

// ==== axil_read_arbiter.sv ====
`timescale 1ns/1ps

module axil_read_arbiter import liang_pkg::*; (
  input  logic clk_i,
  input  logic rst_i,
  axil_read_if.slave  m0,
  axil_read_if.slave  m1,
  axil_read_if.master out
);

  logic busy_q;
  logic sent_q;
  logic grant_q;
  logic last_q;

  logic pick;
  logic cur;
  logic addr_phase;
  logic ar_fire;
  logic r_fire;

  // Round robin on a tie, otherwise whoever asks
  always_comb begin
    if (m0.arvalid && m1.arvalid) begin
      pick = ~last_q;
    end else begin
      pick = m1.arvalid;
    end
  end

  // Grant is decided combinationally only while idle
  assign cur        = busy_q ? grant_q : pick;
  assign addr_phase = ~busy_q | ~sent_q;

  assign out.araddr  = cur ? m1.araddr : m0.araddr;
  assign out.arvalid = addr_phase & (cur ? m1.arvalid : m0.arvalid);
  assign m0.arready  = addr_phase & ~cur & out.arready;
  assign m1.arready  = addr_phase & cur & out.arready;

  // Data beat goes back only to the owner of the outstanding read
  assign out.rready = busy_q & sent_q & (grant_q ? m1.rready : m0.rready);
  assign m0.rvalid  = busy_q & sent_q & ~grant_q & out.rvalid;
  assign m1.rvalid  = busy_q & sent_q & grant_q & out.rvalid;
  assign m0.rdata   = out.rdata;
  assign m1.rdata   = out.rdata;

  assign ar_fire = out.arvalid & out.arready;
  assign r_fire  = out.rvalid & out.rready;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      busy_q  <= 1'b0;
      sent_q  <= 1'b0;
      grant_q <= 1'b0;
      last_q  <= 1'b1;
    end else if (!busy_q) begin
      if (m0.arvalid || m1.arvalid) begin
        busy_q  <= 1'b1;
        grant_q <= pick;
        last_q  <= pick;
        sent_q  <= ar_fire;
      end
    end else if (!sent_q) begin
      if (ar_fire) begin
        sent_q <= 1'b1;
      end
    end else if (r_fire) begin
      // Release once the data beat is taken
      busy_q <= 1'b0;
      sent_q <= 1'b0;
    end
  end

endmodule

// ==== axil_read_if.sv ====
`timescale 1ns/1ps

interface axil_read_if import liang_pkg::*; ();

  // Address channel
  logic [ADDR_WIDTH-1:0] araddr;
  logic                  arvalid;
  logic                  arready;

  // Read data channel
  logic                  rvalid;
  logic [DATA_WIDTH-1:0] rdata;
  logic                  rready;

  modport master (
    output araddr, arvalid, rready,
    input  arready, rvalid, rdata
  );

  modport slave (
    input  araddr, arvalid, rready,
    output arready, rvalid, rdata
  );

endinterface

// ==== fetch_top.f ====
liang_pkg.sv
axil_read_if.sv
pipe_ifu.sv
axil_read_arbiter.sv
pipe_idu.sv
fetch_top.sv
tb_axil_mem.sv
fetch_top_asserts.sv
tb_fetch_top.sv

// ==== fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top import liang_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  flush_i,
  input  pc_t                   flush_pc_i,
  // External memory read port
  output logic [ADDR_WIDTH-1:0] m_araddr_o,
  output logic                  m_arvalid_o,
  input  logic                  m_arready_i,
  input  logic                  m_rvalid_i,
  input  logic [DATA_WIDTH-1:0] m_rdata_i,
  output logic                  m_rready_o,
  // Debug read port
  input  logic [ADDR_WIDTH-1:0] dbg_araddr_i,
  input  logic                  dbg_arvalid_i,
  output logic                  dbg_arready_o,
  output logic                  dbg_rvalid_o,
  output logic [DATA_WIDTH-1:0] dbg_rdata_o,
  input  logic                  dbg_rready_i,
  // Decoded instruction stream
  output pc_t                   dec_pc_o,
  output logic                  dec_is_rtype_o,
  output logic [4:0]            dec_rd_o,
  output logic [4:0]            dec_rs1_o,
  output logic [4:0]            dec_rs2_o,
  output logic [31:0]           dec_imm_o,
  output logic                  dec_valid_o,
  input  logic                  dec_ready_i
);

  axil_read_if ifu_bus ();
  axil_read_if dbg_bus ();
  axil_read_if mem_bus ();

  ifToId_t if_to_id;
  logic    if_valid;
  logic    id_ready;
  dec_t    dec;

  assign dbg_bus.araddr  = dbg_araddr_i;
  assign dbg_bus.arvalid = dbg_arvalid_i;
  assign dbg_bus.rready  = dbg_rready_i;
  assign dbg_arready_o   = dbg_bus.arready;
  assign dbg_rvalid_o    = dbg_bus.rvalid;
  assign dbg_rdata_o     = dbg_bus.rdata;

  assign m_araddr_o      = mem_bus.araddr;
  assign m_arvalid_o     = mem_bus.arvalid;
  assign m_rready_o      = mem_bus.rready;
  assign mem_bus.arready = m_arready_i;
  assign mem_bus.rvalid  = m_rvalid_i;
  assign mem_bus.rdata   = m_rdata_i;

  assign dec_pc_o       = dec.pc;
  assign dec_is_rtype_o = dec.is_rtype;
  assign dec_rd_o       = dec.rd;
  assign dec_rs1_o      = dec.rs1;
  assign dec_rs2_o      = dec.rs2;
  assign dec_imm_o      = dec.imm;

  pipe_ifu ifu_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .flush_i    (flush_i),
    .flush_pc_i (flush_pc_i),
    .bus        (ifu_bus.master),
    .if_to_id_o (if_to_id),
    .if_valid_o (if_valid),
    .id_ready_i (id_ready)
  );

  // Fetch is m0, debug is m1
  axil_read_arbiter arb_i (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .m0    (ifu_bus.slave),
    .m1    (dbg_bus.slave),
    .out   (mem_bus.master)
  );

  pipe_idu idu_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .if_to_id_i  (if_to_id),
    .if_valid_i  (if_valid),
    .id_ready_o  (id_ready),
    .dec_o       (dec),
    .dec_valid_o (dec_valid_o),
    .dec_ready_i (dec_ready_i)
  );

endmodule

// ==== fetch_top_asserts.sv ====
`timescale 1ns/1ps

module fetch_top_asserts import liang_pkg::*; (
  input logic                  clk_i,
  input logic                  rst_i,
  input logic                  flush_i,
  input pc_t                   flush_pc_i,
  input logic [ADDR_WIDTH-1:0] m_araddr_o,
  input logic                  m_arvalid_o,
  input logic                  m_arready_i,
  input logic                  m_rvalid_i,
  input logic                  m_rready_o,
  input logic [ADDR_WIDTH-1:0] dbg_araddr_i,
  input logic                  dbg_arvalid_i,
  input logic                  dbg_arready_o,
  input logic                  dbg_rvalid_o,
  input logic [DATA_WIDTH-1:0] dbg_rdata_o,
  input logic                  dbg_rready_i,
  input pc_t                   dec_pc_o,
  input logic                  dec_is_rtype_o,
  input logic [4:0]            dec_rd_o,
  input logic [4:0]            dec_rs1_o,
  input logic [4:0]            dec_rs2_o,
  input logic [31:0]           dec_imm_o,
  input logic                  dec_valid_o,
  input logic                  dec_ready_i
);

  int         fail_count = 0;
  pc_t        exp_pc;
  pc_t        dbg_addr_q;
  logic [1:0] dbg_wait_q;
  logic       rd_out_q;
  logic       dec_fire;
  logic [47:0] dec_got;

  function automatic logic [31:0] rule_word(input logic [31:0] a);
    logic [31:0] w;
    w      = a ^ 32'h5A5A_A5A5;
    w[6:0] = a[4] ? 7'h33 : 7'h13;
    return w;
  endfunction

  // Expected {is_rtype, rd, rs1, rs2, imm} for the word at pc
  function automatic logic [47:0] dec_fields(input pc_t pc);
    logic [31:0] w;
    logic [31:0] imm;
    logic [4:0]  rs2;
    w   = rule_word(pc);
    rs2 = pc[4] ? w[24:20] : 5'd0;
    imm = pc[4] ? 32'd0 : {{20{w[31]}}, w[31:20]};
    return {pc[4], w[11:7], w[19:15], rs2, imm};
  endfunction

  assign dec_fire = dec_valid_o & dec_ready_i;
  assign dec_got  = {dec_is_rtype_o, dec_rd_o, dec_rs1_o, dec_rs2_o, dec_imm_o};

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      exp_pc     <= RESET_PC;
      dbg_addr_q <= '0;
      dbg_wait_q <= 2'd0;
      rd_out_q   <= 1'b0;
    end else begin
      if (flush_i) begin
        exp_pc <= flush_pc_i;
      end else if (dec_fire) begin
        exp_pc <= exp_pc + 32'd4;
      end
      if (dbg_arvalid_i && dbg_arready_o) begin
        dbg_addr_q <= dbg_araddr_i;
      end
      // Address transfers of the other master while debug waits
      if (!dbg_arvalid_i || dbg_arready_o) begin
        dbg_wait_q <= 2'd0;
      end else if (m_arvalid_o && m_arready_i) begin
        dbg_wait_q <= dbg_wait_q + 2'd1;
      end
      if (m_arvalid_o && m_arready_i) begin
        rd_out_q <= 1'b1;
      end else if (m_rvalid_i && m_rready_o) begin
        rd_out_q <= 1'b0;
      end
    end
  end

  a_reset_low: assert property (@(posedge clk_i)
    rst_i |-> !m_arvalid_o && !m_rready_o && !dbg_arready_o && !dbg_rvalid_o && !dec_valid_o)
    else begin
      fail_count++;
      $error("Outputs were not low during reset at %0t", $time);
    end

  a_dec_pc: assert property (@(posedge clk_i) disable iff (rst_i)
    dec_fire |-> dec_pc_o == exp_pc)
    else begin
      fail_count++;
      $error("** Error at %0t: dec_pc_o = %h, expected %h",
             $time, $sampled(dec_pc_o), $sampled(exp_pc));
    end

  a_dec_fields: assert property (@(posedge clk_i) disable iff (rst_i)
    dec_fire |-> dec_got == dec_fields(exp_pc))
    else begin
      fail_count++;
      $error("** Error at %0t: dec_{is_rtype,rd,rs1,rs2,imm}_o = %h, expected %h",
             $time, $sampled(dec_got), dec_fields($sampled(exp_pc)));
    end

  a_dec_stall: assert property (@(posedge clk_i) disable iff (rst_i)
    dec_valid_o && !dec_ready_i && !flush_i |=>
      dec_valid_o && $stable({dec_pc_o, dec_got}))
    else begin
      fail_count++;
      $error("Decoded outputs changed while the consumer stalled, at %0t", $time);
    end

  a_dbg_data: assert property (@(posedge clk_i) disable iff (rst_i)
    dbg_rvalid_o && dbg_rready_i |-> dbg_rdata_o == rule_word(dbg_addr_q))
    else begin
      fail_count++;
      $error("** Error at %0t: dbg_rdata_o = %h, expected %h",
             $time, $sampled(dbg_rdata_o), rule_word($sampled(dbg_addr_q)));
    end

  a_dbg_grant: assert property (@(posedge clk_i) disable iff (rst_i)
    dbg_wait_q < 2'd2)
    else begin
      fail_count++;
      $error("Debug request waited for two transfers of the fetch unit, at %0t", $time);
    end

  a_ar_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    m_arvalid_o && !m_arready_i |=> m_arvalid_o && $stable(m_araddr_o))
    else begin
      fail_count++;
      $error("Memory address request dropped or changed before transfer, at %0t", $time);
    end

  a_one_read: assert property (@(posedge clk_i) disable iff (rst_i)
    m_arvalid_o |-> !rd_out_q)
    else begin
      fail_count++;
      $error("Second memory read issued before the first data beat, at %0t", $time);
    end

  a_rready: assert property (@(posedge clk_i) disable iff (rst_i)
    m_rready_o |-> rd_out_q)
    else begin
      fail_count++;
      $error("m_rready_o raised with no read outstanding, at %0t", $time);
    end

endmodule

// ==== liang_pkg.sv ====
package liang_pkg;

  // Bus widths
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;

  typedef logic [ADDR_WIDTH-1:0] pc_t;

  // First fetch address out of reset
  localparam pc_t RESET_PC = 32'h2000_0000;

  // Opcode of register-register ALU ops
  localparam logic [6:0] OPC_RTYPE = 7'h33;

  // Read FSM encoding of the fetch unit
  localparam logic [1:0] IF_IDLE      = 2'd0;
  localparam logic [1:0] IF_SEND_ADDR = 2'd1;
  localparam logic [1:0] IF_WAIT_DATA = 2'd2;
  localparam logic [1:0] IF_DONE      = 2'd3;

  // One instruction word, seen either as R-type or as I-type
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } rtype;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } itype;
  } inst_u;

  typedef struct packed {
    pc_t   pc;
    inst_u inst;
  } ifToId_t;

  typedef struct packed {
    pc_t         pc;
    logic        is_rtype;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
  } dec_t;

endpackage

// ==== pipe_idu.sv ====
`timescale 1ns/1ps

module pipe_idu import liang_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    flush_i,
  input  ifToId_t if_to_id_i,
  input  logic    if_valid_i,
  output logic    id_ready_o,
  output dec_t    dec_o,
  output logic    dec_valid_o,
  input  logic    dec_ready_i
);

  inst_u word;
  dec_t  dec_d;
  dec_t  dec_q;
  logic  valid_q;
  logic  id_fire;

  assign word    = if_to_id_i.inst;
  assign id_fire = if_valid_i & id_ready_o;

  // Register can take a word when empty or being drained
  assign id_ready_o  = ~valid_q | dec_ready_i;
  assign dec_o       = dec_q;
  assign dec_valid_o = valid_q;

  always_comb begin
    dec_d.pc  = if_to_id_i.pc;
    // rd and rs1 sit at the same bits in both views
    dec_d.rd  = word.itype.rd;
    dec_d.rs1 = word.itype.rs1;
    if (word.rtype.opcode == OPC_RTYPE) begin
      dec_d.is_rtype = 1'b1;
      dec_d.rs2      = word.rtype.rs2;
      dec_d.imm      = 32'd0;
    end else begin
      dec_d.is_rtype = 1'b0;
      dec_d.rs2      = 5'd0;
      // Sign extend the 12-bit immediate
      dec_d.imm      = {{20{word.itype.imm12[11]}}, word.itype.imm12};
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (id_fire) begin
      valid_q <= 1'b1;
    end else if (dec_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (id_fire) begin
      dec_q <= dec_d;
    end
  end

endmodule

// ==== pipe_ifu.sv ====
`timescale 1ns/1ps

module pipe_ifu import liang_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    flush_i,
  input  pc_t     flush_pc_i,
  // Fetch read port towards the arbiter
  axil_read_if.master bus,
  // Fetch to decode
  output ifToId_t if_to_id_o,
  output logic    if_valid_o,
  input  logic    id_ready_i
);

  logic [1:0] state_q;
  logic [1:0] state_d;
  pc_t        pc_q;
  pc_t        pc_d;
  pc_t        req_addr_q;
  logic       drop_q;
  logic       buf_valid_q;
  inst_u      buf_q;

  logic ar_fire;
  logic r_fire;
  logic if_fire;
  logic keep_beat;

  assign ar_fire   = bus.arvalid & bus.arready;
  assign r_fire    = bus.rvalid & bus.rready;
  assign if_valid_o = buf_valid_q & ~flush_i;
  assign if_fire   = if_valid_o & id_ready_i;
  // A beat of a squashed request is taken off the bus but never buffered
  assign keep_beat = r_fire & ~drop_q & ~flush_i;

  assign bus.araddr  = req_addr_q;
  assign bus.arvalid = (state_q == IF_SEND_ADDR);
  assign bus.rready  = (state_q == IF_WAIT_DATA) & (~buf_valid_q | if_fire);

  assign if_to_id_o.pc   = pc_q;
  assign if_to_id_o.inst = buf_q;

  assign pc_d = flush_i ? flush_pc_i :
                if_fire ? pc_q + 32'd4 : pc_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IF_IDLE:      state_d = IF_SEND_ADDR;
      IF_SEND_ADDR: if (ar_fire) state_d = IF_WAIT_DATA;
      IF_WAIT_DATA: if (r_fire) state_d = keep_beat ? IF_DONE : IF_SEND_ADDR;
      IF_DONE:      if (flush_i || if_fire) state_d = IF_SEND_ADDR;
      default:      state_d = IF_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= IF_IDLE;
      pc_q    <= RESET_PC;
    end else begin
      state_q <= state_d;
      pc_q    <= pc_d;
    end
  end

  // Request address is frozen while arvalid is up
  always_ff @(posedge clk_i) begin
    if (state_d == IF_SEND_ADDR && state_q != IF_SEND_ADDR) begin
      req_addr_q <= pc_d;
    end
  end

  // Marks a request issued before a flush
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      drop_q <= 1'b0;
    end else if (r_fire) begin
      drop_q <= 1'b0;
    end else if (flush_i && (state_q == IF_SEND_ADDR || state_q == IF_WAIT_DATA)) begin
      drop_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      buf_valid_q <= 1'b0;
    end else if (flush_i) begin
      buf_valid_q <= 1'b0;
    end else if (keep_beat) begin
      buf_valid_q <= 1'b1;
    end else if (if_fire) begin
      buf_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (keep_beat) begin
      buf_q <= bus.rdata;
    end
  end

endmodule

// ==== tb_axil_mem.sv ====
`timescale 1ns/1ps

module tb_axil_mem import liang_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic [ADDR_WIDTH-1:0] araddr_i,
  input  logic                  arvalid_i,
  output logic                  arready_o,
  output logic                  rvalid_o,
  output logic [DATA_WIDTH-1:0] rdata_o,
  input  logic                  rready_i
);

  logic                  busy_q;
  logic [1:0]            wait_q;
  logic [ADDR_WIDTH-1:0] addr_q;

  // Word stored at address a, with an R-type or I-type opcode picked by a[4]
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    logic [31:0] w;
    w      = a ^ 32'h5A5A_A5A5;
    w[6:0] = a[4] ? OPC_RTYPE : 7'h13;
    return w;
  endfunction

  always @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      busy_q    <= 1'b0;
      wait_q    <= 2'd0;
      addr_q    <= '0;
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
      rdata_o   <= '0;
    end else if (!busy_q) begin
      // Address ready is withheld on random cycles
      arready_o <= ($urandom % 2) != 0;
      if (arvalid_i && arready_o) begin
        busy_q    <= 1'b1;
        arready_o <= 1'b0;
        addr_q    <= araddr_i;
        wait_q    <= 2'($urandom % 4);
      end
    end else if (!rvalid_o) begin
      // Count down the random latency, then present the beat
      if (wait_q == 2'd0) begin
        rvalid_o <= 1'b1;
        rdata_o  <= mem_word(addr_q);
      end else begin
        wait_q <= wait_q - 2'd1;
      end
    end else if (rready_i) begin
      rvalid_o  <= 1'b0;
      busy_q    <= 1'b0;
      arready_o <= 1'b1;
    end
  end

endmodule

// ==== tb_fetch_top.sv ====
`timescale 1ns/1ps

module tb_fetch_top import liang_pkg::*; #(
  parameter logic [31:0] SEED = 32'h965659ea
);

  localparam int MAX_LAT  = 3;
  // Decodes requested by tests 1 to 6
  localparam int N_FETCH  = 1 + 16 + 24 + 16 + 20 + 16;
  localparam int WD_CYCLES = 20 * N_FETCH * (MAX_LAT + 4);

  logic                  clk_i = 1'b0;
  logic                  rst_i;
  logic                  flush_i;
  pc_t                   flush_pc_i;
  logic [ADDR_WIDTH-1:0] m_araddr_o;
  logic                  m_arvalid_o;
  logic                  m_arready_i;
  logic                  m_rvalid_i;
  logic [DATA_WIDTH-1:0] m_rdata_i;
  logic                  m_rready_o;
  logic [ADDR_WIDTH-1:0] dbg_araddr_i;
  logic                  dbg_arvalid_i;
  logic                  dbg_arready_o;
  logic                  dbg_rvalid_o;
  logic [DATA_WIDTH-1:0] dbg_rdata_o;
  logic                  dbg_rready_i;
  pc_t                   dec_pc_o;
  logic                  dec_is_rtype_o;
  logic [4:0]            dec_rd_o;
  logic [4:0]            dec_rs1_o;
  logic [4:0]            dec_rs2_o;
  logic [31:0]           dec_imm_o;
  logic                  dec_valid_o;
  logic                  dec_ready_i = 1'b1;

  logic stall_en = 1'b0;
  int   n_dec = 0;
  int   n_tests = 0;
  int   n_failed = 0;
  int   errs_seen = 0;

  fetch_top dut_i (.*);

  tb_axil_mem mem_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .araddr_i  (m_araddr_o),
    .arvalid_i (m_arvalid_o),
    .arready_o (m_arready_i),
    .rvalid_o  (m_rvalid_i),
    .rdata_o   (m_rdata_i),
    .rready_i  (m_rready_o)
  );

  bind fetch_top fetch_top_asserts chk_i (.*);

  always #4 clk_i = ~clk_i;

  // Consumer back-pressure and handshake count
  always @(posedge clk_i) begin
    dec_ready_i <= stall_en ? (($urandom % 4) != 0) : 1'b1;
    if (dec_valid_o && dec_ready_i) begin
      n_dec <= n_dec + 1;
    end
  end

  task automatic wait_decodes(input int n);
    int target;
    target = n_dec + n;
    while (n_dec < target) begin
      @(posedge clk_i);
    end
  endtask

  task automatic dbg_read(input logic [31:0] addr);
    @(posedge clk_i);
    dbg_araddr_i  <= addr;
    dbg_arvalid_i <= 1'b1;
    do @(posedge clk_i); while (!dbg_arready_o);
    dbg_arvalid_i <= 1'b0;
    do @(posedge clk_i); while (!dbg_rvalid_o);
  endtask

  task automatic dbg_burst(input int n);
    repeat (n) begin
      repeat ($urandom % 8) @(posedge clk_i);
      dbg_read(32'h2000_0000 | ($urandom & 32'h0000_0ffc));
    end
  endtask

  task automatic flush_and_run(input logic [31:0] base, input int n);
    repeat ($urandom % 10) @(posedge clk_i);
    flush_i    <= 1'b1;
    flush_pc_i <= base | ($urandom & 32'h0000_fffc);
    @(posedge clk_i);
    flush_i <= 1'b0;
    wait_decodes(n);
  endtask

  task automatic report_test(input string name);
    int errs;
    errs = dut_i.chk_i.fail_count;
    n_tests++;
    if (errs != errs_seen) begin
      n_failed++;
      $display("Test %0d %s: FAILED with %0d assertion errors", n_tests, name, errs - errs_seen);
    end else begin
      $display("Test %0d %s: ok", n_tests, name);
    end
    errs_seen = errs;
  endtask

  initial begin
    void'($urandom(SEED));
    rst_i         = 1'b1;
    flush_i       = 1'b0;
    flush_pc_i    = RESET_PC;
    dbg_araddr_i  = '0;
    dbg_arvalid_i = 1'b0;
    dbg_rready_i  = 1'b1;
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;

    wait_decodes(1);
    report_test("reset and first fetch");
    wait_decodes(16);
    report_test("sequential decode");
    stall_en <= 1'b1;
    wait_decodes(24);
    stall_en <= 1'b0;
    report_test("decode back-pressure");
    flush_and_run(32'h3000_0000, 8);
    // Upper-half target gives I-type words a negative immediate
    flush_and_run(32'hb000_0000, 8);
    report_test("flush redirect");
    fork
      wait_decodes(20);
      dbg_burst(4);
    join
    report_test("debug reads during fetch");
    stall_en <= 1'b1;
    fork
      wait_decodes(16);
      dbg_burst(3);
    join
    stall_en <= 1'b0;
    report_test("memory bus protocol");

    $display("Tests run: %0d, failed: %0d, assertion errors: %0d",
             n_tests, n_failed, dut_i.chk_i.fail_count);
    if (n_failed == 0 && dut_i.chk_i.fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #(WD_CYCLES * 8);
    $display("Watchdog expired after %0d cycles before the tests finished", WD_CYCLES);
    $display("Verification failed");
    $finish;
  end

endmodule
